//--- bg_pkg.sv
`default_nettype none

package bg_pkg;

	// Pixel and bus widths
	typedef logic [3:0]  pix_t;       // One pixel or color nibble
	typedef logic [15:0] mem_addr_t;  // Word address on the memory channel
	typedef logic [15:0] mem_data_t;  // Four pixels with the leftmost in 15:12
	typedef logic [63:0] row_bits_t;  // One tile row of 16 pixels
	typedef logic [7:0]  color_t;     // Palette index sent to the display
	typedef logic [9:0]  coord_t;     // Display coordinate
	typedef logic [3:0]  reg_addr_t;  // Wishbone register address

	// Register map
	localparam reg_addr_t REG_CTRL     = 4'd0;
	localparam reg_addr_t REG_SCROLL_X = 4'd1;
	localparam reg_addr_t REG_SCROLL_Y = 4'd2;
	localparam reg_addr_t REG_MAP_BASE = 4'd3;
	localparam reg_addr_t REG_SET_BASE = 4'd4;

	// Renderer configuration as held by the register file
	typedef struct packed {
		logic        enable;
		logic [1:0]  map_pitch;  // Map row is 16 << map_pitch words
		logic        set_pitch;  // Set for 64 words per pixel row
		pix_t        pal_hi;
		logic [15:0] scroll_x;
		logic [15:0] scroll_y;
		mem_addr_t   map_base;
		mem_addr_t   set_base;
	} bg_cfg_t;

	// Tile fetcher FSM
	typedef enum logic [2:0] {
		f_idle,
		f_map_req,
		f_map_wait,
		f_row_req,
		f_row_wait,
		f_wait_blit
	} fetch_state_t;

endpackage

`default_nettype wire

//--- bg_regs.sv
`timescale 1ns/1ns
`default_nettype none

module bg_regs (
	input  wire                    CLK,
	input  wire                    RSTb,
	input  wire                    wb_cyc,
	input  wire                    wb_stb,
	input  wire                    wb_we,
	input  wire bg_pkg::reg_addr_t wb_adr,
	input  wire bg_pkg::mem_data_t wb_dat_w,
	output bg_pkg::mem_data_t      wb_dat_r,
	output logic                   wb_ack,
	output bg_pkg::bg_cfg_t        cfg
);

	logic              access;
	bg_pkg::mem_data_t rd_mux;

	// New strobe only, so each access gets a single ack
	assign access = wb_cyc && wb_stb && !wb_ack;

	always_comb
	begin
		case (wb_adr)
			bg_pkg::REG_CTRL:
				rd_mux = {8'h00, cfg.pal_hi, cfg.set_pitch, cfg.map_pitch, cfg.enable};
			bg_pkg::REG_SCROLL_X:
				rd_mux = cfg.scroll_x;
			bg_pkg::REG_SCROLL_Y:
				rd_mux = cfg.scroll_y;
			bg_pkg::REG_MAP_BASE:
				rd_mux = cfg.map_base;
			bg_pkg::REG_SET_BASE:
				rd_mux = cfg.set_base;
			default:
				rd_mux = 16'h0000;  // Unmapped
		endcase
	end

	always_ff @(posedge CLK)
	begin
		if (!RSTb)
		begin
			wb_ack   <= 1'b0;
			wb_dat_r <= 16'h0000;
			cfg      <= '0;
		end
		else
		begin
			wb_ack <= access;
			if (access)
				wb_dat_r <= rd_mux;
			// Write lands on the same edge that raises ack
			if (access && wb_we)
			begin
				case (wb_adr)
					bg_pkg::REG_CTRL:
					begin
						cfg.enable    <= wb_dat_w[0];
						cfg.map_pitch <= wb_dat_w[2:1];
						cfg.set_pitch <= wb_dat_w[3];
						cfg.pal_hi    <= wb_dat_w[7:4];
					end
					bg_pkg::REG_SCROLL_X:
						cfg.scroll_x <= wb_dat_w;
					bg_pkg::REG_SCROLL_Y:
						cfg.scroll_y <= wb_dat_w;
					bg_pkg::REG_MAP_BASE:
						cfg.map_base <= wb_dat_w;
					bg_pkg::REG_SET_BASE:
						cfg.set_base <= wb_dat_w;
					default:
						;
				endcase
			end
		end
	end

endmodule

`default_nettype wire

//--- bg_renderer.sv
`timescale 1ns/1ns
`default_nettype none

module bg_renderer #(
	parameter bg_pkg::coord_t H_START = 10'd48,
	parameter bg_pkg::coord_t H_END   = 10'd320
) (
	input  wire                    CLK,
	input  wire                    RSTb,
	input  wire                    wb_cyc,
	input  wire                    wb_stb,
	input  wire                    wb_we,
	input  wire bg_pkg::reg_addr_t wb_adr,
	input  wire bg_pkg::mem_data_t wb_dat_w,
	output bg_pkg::mem_data_t      wb_dat_r,
	output logic                   wb_ack,
	input  wire                    V_tick,
	input  wire                    H_tick,
	input  wire bg_pkg::coord_t    display_x,
	input  wire bg_pkg::coord_t    display_y,  // Display side compatibility only
	input  wire                    re,
	output bg_pkg::color_t         color_index,
	output bg_pkg::mem_addr_t      memory_address,
	input  wire bg_pkg::mem_data_t memory_data,
	output logic                   rvalid,
	input  wire                    rready
);

	bg_pkg::bg_cfg_t   cfg;
	logic              row_valid;
	bg_pkg::row_bits_t row_bits;
	logic              row_ack;
	logic              wr_en;
	bg_pkg::coord_t    wr_addr;
	bg_pkg::pix_t      wr_pix;

	bg_regs u_regs (
		.CLK, .RSTb, .wb_cyc, .wb_stb, .wb_we, .wb_adr, .wb_dat_w, .wb_dat_r, .wb_ack, .cfg
	);

	tile_fetcher u_fetch (
		.CLK, .RSTb, .V_tick, .H_tick, .cfg,
		.memory_address, .rvalid, .memory_data, .rready,
		.row_valid, .row_bits, .row_ack
	);

	scanline_blitter #(.H_START(H_START), .H_END(H_END)) u_blit (
		.CLK, .RSTb, .H_tick, .cfg,
		.row_valid, .row_bits, .row_ack,
		.wr_en, .wr_addr, .wr_pix
	);

	scanline_buffers #(.H_START(H_START), .H_END(H_END)) u_lines (
		.CLK, .RSTb, .H_tick, .cfg,
		.wr_en, .wr_addr, .wr_pix,
		.display_x, .re, .color_index
	);

endmodule

`default_nettype wire

//--- bg_renderer_chk.sv
`timescale 1ns/1ns
`default_nettype none

module bg_renderer_chk (
	input wire                    CLK,
	input wire                    RSTb,
	input wire                    rvalid,
	input wire                    rready,
	input wire bg_pkg::mem_addr_t memory_address,
	input wire                    wb_ack
);

	int fail_cnt = 0;  // Assertion failures so far

	// Request held with a stable address until the responder answers
	a_req_hold: assert property (@(posedge CLK) disable iff (!RSTb)
		rvalid && !rready |=> rvalid && $stable(memory_address))
	else
	begin
		$error("rvalid dropped or address changed before rready");
		fail_cnt++;
	end

	a_ack_single: assert property (@(posedge CLK) disable iff (!RSTb) wb_ack |=> !wb_ack)
	else
	begin
		$error("wb_ack high for more than one cycle");
		fail_cnt++;
	end

	a_reset_idle: assert property (@(posedge CLK) !RSTb |=> !rvalid)
	else
	begin
		$error("rvalid high during reset");
		fail_cnt++;
	end

endmodule

bind bg_renderer bg_renderer_chk u_chk (
	.CLK            (CLK),
	.RSTb           (RSTb),
	.rvalid         (rvalid),
	.rready         (rready),
	.memory_address (memory_address),
	.wb_ack         (wb_ack)
);

`default_nettype wire

//--- scanline_blitter.sv
`timescale 1ns/1ns
`default_nettype none

module scanline_blitter #(
	parameter bg_pkg::coord_t H_START = 10'd48,
	parameter bg_pkg::coord_t H_END   = 10'd320
) (
	input  wire                    CLK,
	input  wire                    RSTb,
	input  wire                    H_tick,
	input  wire bg_pkg::bg_cfg_t   cfg,
	input  wire                    row_valid,
	input  wire bg_pkg::row_bits_t row_bits,
	output logic                   row_ack,
	output logic                   wr_en,
	output bg_pkg::coord_t         wr_addr,
	output bg_pkg::pix_t           wr_pix
);

	localparam bg_pkg::coord_t ACTIVE_W = H_END - H_START;

	bg_pkg::row_bits_t shift;
	logic [4:0]        pix_cnt;   // Pixels left in shift
	logic [3:0]        skip_cnt;  // Fine scroll pixels still to drop
	bg_pkg::coord_t    wr_pos;
	logic              emit;

	assign emit = (pix_cnt != 5'd0);

	// Take a new row as the last pixel leaves, so output never stalls
	assign row_ack = row_valid && (pix_cnt <= 5'd1) && !H_tick;

	// Past the active width the rows are still taken but dropped
	assign wr_en   = emit && (skip_cnt == 4'd0) && (wr_pos < ACTIVE_W);
	assign wr_addr = wr_pos;
	assign wr_pix  = shift[63:60];

	always_ff @(posedge CLK)
	begin
		if (row_ack)
			shift <= row_bits;
		else if (emit)
			shift <= {shift[59:0], 4'h0};
	end

	always_ff @(posedge CLK)
	begin
		if (!RSTb)
		begin
			pix_cnt  <= 5'd0;
			skip_cnt <= 4'd0;
			wr_pos   <= 10'd0;
		end
		else if (H_tick)
		begin
			pix_cnt  <= 5'd0;
			skip_cnt <= cfg.scroll_x[3:0];
			wr_pos   <= 10'd0;
		end
		else
		begin
			if (emit)
			begin
				if (skip_cnt != 4'd0)
					skip_cnt <= skip_cnt - 4'd1;
				else if (wr_pos < ACTIVE_W)
					wr_pos <= wr_pos + 10'd1;
			end
			if (row_ack)
				pix_cnt <= 5'd16;
			else if (emit)
				pix_cnt <= pix_cnt - 5'd1;
		end
	end

endmodule

`default_nettype wire

//--- scanline_bram.sv
`timescale 1ns/1ns
`default_nettype none

module scanline_bram #(
	parameter int BITS         = 4,
	parameter int ADDRESS_BITS = 10
) (
	input  wire                    CLK,
	input  wire [ADDRESS_BITS-1:0] rd_addr,
	output logic [BITS-1:0]        rd_data,
	input  wire [ADDRESS_BITS-1:0] wr_addr,
	input  wire [BITS-1:0]         wr_data,
	input  wire                    wr
);

	logic [BITS-1:0] mem [0:(1 << ADDRESS_BITS) - 1];

	// Registered read to map onto block RAM
	always_ff @(posedge CLK)
	begin
		if (wr)
			mem[wr_addr] <= wr_data;
		rd_data <= mem[rd_addr];
	end

endmodule

`default_nettype wire

//--- scanline_buffers.sv
`timescale 1ns/1ns
`default_nettype none

module scanline_buffers #(
	parameter bg_pkg::coord_t H_START = 10'd48,
	parameter bg_pkg::coord_t H_END   = 10'd320
) (
	input  wire                  CLK,
	input  wire                  RSTb,
	input  wire                  H_tick,
	input  wire bg_pkg::bg_cfg_t cfg,
	input  wire                  wr_en,
	input  wire bg_pkg::coord_t  wr_addr,
	input  wire bg_pkg::pix_t    wr_pix,
	input  wire bg_pkg::coord_t  display_x,
	input  wire                  re,
	output bg_pkg::color_t       color_index
);

	logic           active_half;  // Half being written by the blitter
	logic           disp_sel;     // Half read last cycle
	logic           blank;
	bg_pkg::coord_t rd_addr;
	bg_pkg::pix_t   rd_data [2];

	assign rd_addr = display_x - H_START;

	for (genvar j = 0; j < 2; j++)
	begin : g_half
		scanline_bram #(
			.BITS         ($bits(bg_pkg::pix_t)),
			.ADDRESS_BITS ($bits(bg_pkg::coord_t))
		) u_bram (
			.CLK     (CLK),
			.rd_addr (rd_addr),
			.rd_data (rd_data[j]),
			.wr_addr (wr_addr),
			.wr_data (wr_pix),
			.wr      (wr_en && (active_half == (j == 1)))
		);
	end

	always_ff @(posedge CLK)
	begin
		if (!RSTb)
		begin
			active_half <= 1'b0;
			disp_sel    <= 1'b1;
			blank       <= 1'b1;
		end
		else
		begin
			if (H_tick)
				active_half <= ~active_half;
			// Both follow the RAM read by one cycle
			disp_sel <= ~active_half;
			blank    <= !re || !cfg.enable || (display_x < H_START) || (display_x >= H_END);
		end
	end

	assign color_index = blank ? 8'h00 : {cfg.pal_hi, rd_data[disp_sel]};

endmodule

`default_nettype wire

//--- src.f
bg_pkg.sv
bg_regs.sv
tile_fetcher.sv
scanline_blitter.sv
scanline_bram.sv
scanline_buffers.sv
bg_renderer.sv
bg_renderer_chk.sv
tb_bg_renderer.sv

//--- tb_bg_renderer.sv
`timescale 1ns/1ns
`default_nettype none

module tb_bg_renderer;

	localparam bg_pkg::coord_t H_START = 10'd48;
	localparam bg_pkg::coord_t H_END   = 10'd320;
	localparam int LINE_CYC  = 600;        // Cycles between H_tick pulses
	localparam int SWEEP_CYC = H_END + 9;  // Cycles used by one display sweep
	localparam int WAIT_MAX  = 800;

	logic              CLK, RSTb, wb_cyc, wb_stb, wb_we, wb_ack;
	logic              V_tick, H_tick, re, rvalid, rready;
	bg_pkg::reg_addr_t wb_adr;
	bg_pkg::mem_data_t wb_dat_w, wb_dat_r, memory_data;
	bg_pkg::mem_addr_t memory_address;
	bg_pkg::coord_t    display_x, display_y, ref_line, cmp_x;
	bg_pkg::color_t    color_index, cmp_expected;
	bg_pkg::bg_cfg_t   exp_cfg;  // Register values the reference works from
	logic              cmp_en, cmp_pending;
	integer            seed;
	int                delay;

	bg_renderer #(.H_START(H_START), .H_END(H_END)) UUT (
		.CLK, .RSTb, .wb_cyc, .wb_stb, .wb_we, .wb_adr, .wb_dat_w, .wb_dat_r, .wb_ack,
		.V_tick, .H_tick, .display_x, .display_y, .re, .color_index,
		.memory_address, .memory_data, .rvalid, .rready
	);

	// Memory contents, a fixed function of the whole word address
	function automatic bg_pkg::mem_data_t mem_word(input bg_pkg::mem_addr_t a);
		return (a * 16'h9E37) ^ {a[6:0], a[15:7]} ^ 16'h5A5A;
	endfunction

	function automatic bg_pkg::color_t ref_color(input bg_pkg::bg_cfg_t c,
			input bg_pkg::coord_t x, input logic rd_en, input bg_pkg::coord_t line);
		int                pos, mpitch, tpr, spitch;
		bg_pkg::mem_addr_t a;
		bg_pkg::mem_data_t w;
		logic [7:0]        idx;
		if (!rd_en || !c.enable || x < H_START || x >= H_END)
			return 8'h00;
		pos    = (x - H_START) + c.scroll_x[3:0];  // Fine scroll pixels dropped first
		mpitch = 16 << c.map_pitch;
		tpr    = c.set_pitch ? 16 : 8;
		spitch = c.set_pitch ? 64 : 32;
		a   = c.map_base + ((line / 16) % 64) * mpitch + ((c.scroll_x / 16 + pos / 16) % mpitch);
		w   = mem_word(a);
		idx = w[7:0];
		a = c.set_base + (idx / tpr) * 16 * spitch + (line % 16) * spitch
			+ (idx % tpr) * 4 + (pos % 16) / 4;
		w = mem_word(a);
		return {c.pal_hi, w[15 - 4 * (pos % 4) -: 4]};  // Leftmost pixel on top
	endfunction

	function automatic bg_pkg::bg_cfg_t make_cfg(input logic en, input logic [1:0] mp,
			input logic sp, input bg_pkg::pix_t pal, input logic [15:0] sx, sy, mb, sb);
		bg_pkg::bg_cfg_t c;
		c = '{en, mp, sp, pal, sx, sy, mb, sb};
		return c;
	endfunction

	task automatic stop_failed();
		$display("Errors found");
		$fatal(1, "Simulation stopped on first failure");
	endtask

	task automatic check_value(input logic [15:0] expected, actual, input string what);
		if (actual !== expected)
		begin
			$display("[ERROR] %0t ns: %s expected %h, got %h", $time, what, expected, actual);
			stop_failed();
		end
	endtask

	task automatic step(input int n);
		repeat (n)
		begin
			@(posedge CLK);
			#1;
		end
	endtask

	task automatic wb_access(input bg_pkg::reg_addr_t adr, input logic we,
			input bg_pkg::mem_data_t wdat, output bg_pkg::mem_data_t rdat);
		int n;
		step(1);
		{wb_cyc, wb_stb, wb_we, wb_adr, wb_dat_w} = {1'b1, 1'b1, we, adr, wdat};
		n = 0;
		do
		begin
			step(1);
			n++;
		end
		while (!wb_ack && n < 20);
		if (!wb_ack)
		begin
			$display("Timeout: no Wishbone ack for register %0d", adr);
			stop_failed();
		end
		else
		begin
			rdat = wb_dat_r;
			{wb_cyc, wb_stb, wb_we} = 3'b000;
			step(1);
			check_value(16'h0000, {15'd0, wb_ack}, "ack after access");
		end
	endtask

	task automatic write_verify(input bg_pkg::reg_addr_t adr, input bg_pkg::mem_data_t val, exp);
		bg_pkg::mem_data_t rd;
		wb_access(adr, 1'b1, val, rd);
		wb_access(adr, 1'b0, 16'h0000, rd);
		check_value(exp, rd, $sformatf("readback of register %0d", adr));
	endtask

	task automatic configure(input bg_pkg::bg_cfg_t c);
		bg_pkg::mem_data_t ctrl;
		ctrl = {8'hA5, c.pal_hi, c.set_pitch, c.map_pitch, c.enable};  // Top byte reads zero
		write_verify(bg_pkg::REG_CTRL, ctrl, {8'h00, ctrl[7:0]});
		write_verify(bg_pkg::REG_SCROLL_X, c.scroll_x, c.scroll_x);
		write_verify(bg_pkg::REG_SCROLL_Y, c.scroll_y, c.scroll_y);
		write_verify(bg_pkg::REG_MAP_BASE, c.map_base, c.map_base);
		write_verify(bg_pkg::REG_SET_BASE, c.set_base, c.set_base);
		exp_cfg = c;
	endtask

	task automatic wait_fetch_idle();
		int n;
		n = 0;
		while (UUT.u_fetch.state != bg_pkg::f_idle && n < WAIT_MAX)
		begin
			step(1);
			n++;
		end
		if (UUT.u_fetch.state != bg_pkg::f_idle)
		begin
			$display("Timeout: tile fetcher did not finish its line");
			stop_failed();
		end
	endtask

	task automatic sweep_line(input bg_pkg::coord_t line);
		ref_line  = line;
		display_y = line;
		for (int x = 0; x < H_END + 8; x++)
		begin
			step(1);
			display_x = bg_pkg::coord_t'(x);
			re        = (x % 50) != 7;  // Short gaps in the read enable
			cmp_en    = 1'b1;
		end
		step(1);
		cmp_en = 1'b0;
	endtask

	// One line period, with the display showing the line fetched in the period before
	task automatic line_slot(input bg_pkg::coord_t shown, input logic sweep);
		wait_fetch_idle();
		step(1);
		H_tick = 1'b1;
		step(1);
		H_tick = 1'b0;
		if (sweep)
			sweep_line(shown);
		else
			step(SWEEP_CYC);
		step(LINE_CYC - 2 - SWEEP_CYC);
	endtask

	task automatic run_lines(input int n);
		bg_pkg::coord_t first;
		first = exp_cfg.scroll_y[9:0];
		step(1);
		V_tick = 1'b1;
		step(1);
		V_tick = 1'b0;
		line_slot(first, 1'b0);  // Fills the first half only
		for (int k = 0; k < n; k++)
			line_slot(bg_pkg::coord_t'(first + k), 1'b1);
	endtask

	initial
	begin
		CLK = 1'b0;
		forever
			#2 CLK = ~CLK;
	end

	// Memory responder with a random delay per request
	initial
	begin
		seed = 82810;
		forever
		begin
			step(1);
			rready = 1'b0;
			if (rvalid)
			begin
				delay = ($random(seed) & 32'h7FFF_FFFF) % 6;
				step(delay);
				memory_data = mem_word(memory_address);
				rready      = 1'b1;
			end
		end
	end

	// Output of display_x shows one cycle later
	always @(posedge CLK)
	begin
		cmp_pending  <= cmp_en;
		cmp_x        <= display_x;
		cmp_expected <= ref_color(exp_cfg, display_x, re, ref_line);
	end

	always @(negedge CLK)
		if (cmp_pending)
			check_value({8'h00, cmp_expected}, {8'h00, color_index},
				$sformatf("color_index at x=%0d line %0d", cmp_x, ref_line));

	// Bound assertion failures end the run at once
	always @(UUT.u_chk.fail_cnt)
		if (UUT.u_chk.fail_cnt != 0)
		begin
			$display("Assertion failure reported by the bound checker");
			stop_failed();
		end

	initial
	begin
		{RSTb, wb_cyc, wb_stb, wb_we, V_tick, H_tick, re, rready, cmp_en} = '0;
		{wb_adr, wb_dat_w, memory_data, display_x, display_y, ref_line} = '0;
		exp_cfg = '0;
		step(10);
		RSTb = 1'b1;
		write_verify(bg_pkg::REG_SCROLL_X, 16'hA5C3, 16'hA5C3);
		write_verify(4'd7, 16'h1234, 16'h0000);
		write_verify(4'd15, 16'hFFFF, 16'h0000);
		configure(make_cfg(1'b0, 2'd0, 1'b0, 4'hF, 16'd0, 16'd0, 16'h1000, 16'h4000));
		run_lines(1);
		configure(make_cfg(1'b1, 2'd0, 1'b0, 4'h3, 16'd0, 16'd0, 16'h1000, 16'h4000));
		run_lines(2);
		configure(make_cfg(1'b1, 2'd0, 1'b0, 4'h6, 16'd87, 16'd14, 16'h1000, 16'h4000));
		run_lines(3);
		configure(make_cfg(1'b1, 2'd1, 1'b1, 4'h9, 16'h0125, 16'h0040, 16'h2345, 16'h8000));
		run_lines(2);
		configure(make_cfg(1'b1, 2'd2, 1'b1, 4'hA, 16'h01F3, 16'h03FF, 16'h0800, 16'hC000));
		run_lines(2);
		configure(make_cfg(1'b1, 2'd3, 1'b0, 4'hC, 16'h0F0F, 16'h0123, 16'hF000, 16'h6000));
		run_lines(2);
		if (UUT.u_chk.fail_cnt == 0)
			$display("No errors");
		else
			$display("Errors found");
		$finish;
	end

endmodule

`default_nettype wire

//--- tile_fetcher.sv
`timescale 1ns/1ns
`default_nettype none

module tile_fetcher (
	input  wire                    CLK,
	input  wire                    RSTb,
	input  wire                    V_tick,
	input  wire                    H_tick,
	input  wire bg_pkg::bg_cfg_t   cfg,
	output bg_pkg::mem_addr_t      memory_address,
	output logic                   rvalid,
	input  wire bg_pkg::mem_data_t memory_data,
	input  wire                    rready,
	output logic                   row_valid,
	output bg_pkg::row_bits_t      row_bits,
	input  wire                    row_ack
);

	localparam int TILES = 18;  // 272 pixels plus up to 15 of fine scroll

	bg_pkg::fetch_state_t state;
	bg_pkg::coord_t       line_cnt;
	bg_pkg::coord_t       fetch_line;
	logic [4:0]           tile_cnt;
	logic [1:0]           word_cnt;
	logic [7:0]           tile_idx;
	bg_pkg::row_bits_t    row_buf [2];
	logic [1:0]           full;
	logic                 wr_sel;  // Buffer being filled
	logic                 rd_sel;  // Buffer offered to the blitter
	bg_pkg::mem_addr_t    map_mask;
	bg_pkg::mem_addr_t    map_row;
	bg_pkg::mem_addr_t    map_col;
	bg_pkg::mem_addr_t    map_addr;
	bg_pkg::mem_addr_t    set_off;
	bg_pkg::mem_addr_t    row_addr;

	assign row_valid = full[rd_sel];
	assign row_bits  = row_buf[rd_sel];

	// Word addresses for the current tile
	always_comb
	begin
		map_mask = (bg_pkg::mem_addr_t'(16) << cfg.map_pitch) - 16'd1;
		map_row  = bg_pkg::mem_addr_t'(fetch_line[9:4]) << (3'd4 + cfg.map_pitch);
		map_col  = (bg_pkg::mem_addr_t'(cfg.scroll_x[15:4]) + bg_pkg::mem_addr_t'(tile_cnt))
			& map_mask;
		map_addr = cfg.map_base + map_row + map_col;
		if (cfg.set_pitch)  // 16 tiles across
			set_off = {2'b00, tile_idx[7:4], fetch_line[3:0], tile_idx[3:0], word_cnt};
		else                // 8 tiles across
			set_off = {2'b00, tile_idx[7:3], fetch_line[3:0], tile_idx[2:0], word_cnt};
		row_addr = cfg.set_base + set_off;
	end

	// Payload
	always_ff @(posedge CLK)
	begin
		if (state == bg_pkg::f_idle && H_tick)
			fetch_line <= line_cnt;
		if (state == bg_pkg::f_map_wait && rready)
			tile_idx <= memory_data[7:0];
		if (state == bg_pkg::f_row_wait && rready)
			row_buf[wr_sel] <= {row_buf[wr_sel][47:0], memory_data};  // First word ends on top
		if (state == bg_pkg::f_map_req)
			memory_address <= map_addr;
		else if (state == bg_pkg::f_row_req)
			memory_address <= row_addr;
	end

	always_ff @(posedge CLK)
	begin
		if (!RSTb)
		begin
			state    <= bg_pkg::f_idle;
			rvalid   <= 1'b0;
			line_cnt <= 10'd0;
			tile_cnt <= 5'd0;
			word_cnt <= 2'd0;
			full     <= 2'b00;
			wr_sel   <= 1'b0;
			rd_sel   <= 1'b0;
		end
		else
		begin
			if (V_tick)
				line_cnt <= cfg.scroll_y[9:0];
			else if (H_tick)
				line_cnt <= line_cnt + 10'd1;

			if (row_ack)
			begin
				full[rd_sel] <= 1'b0;
				rd_sel       <= ~rd_sel;
			end

			case (state)
				bg_pkg::f_idle:
					if (H_tick && cfg.enable)
					begin
						tile_cnt <= 5'd0;
						state    <= bg_pkg::f_map_req;
					end
				bg_pkg::f_map_req:
				begin
					rvalid <= 1'b1;
					state  <= bg_pkg::f_map_wait;
				end
				bg_pkg::f_map_wait:
					if (rready)
					begin
						rvalid   <= 1'b0;
						word_cnt <= 2'd0;
						state    <= full[wr_sel] ? bg_pkg::f_wait_blit : bg_pkg::f_row_req;
					end
				bg_pkg::f_wait_blit:
					if (!full[wr_sel])
						state <= bg_pkg::f_row_req;
				bg_pkg::f_row_req:
				begin
					rvalid <= 1'b1;
					state  <= bg_pkg::f_row_wait;
				end
				bg_pkg::f_row_wait:
					if (rready)
					begin
						rvalid   <= 1'b0;
						word_cnt <= word_cnt + 2'd1;
						if (word_cnt == 2'd3)
						begin
							// Row complete, hand it over
							full[wr_sel] <= 1'b1;
							wr_sel       <= ~wr_sel;
							tile_cnt     <= tile_cnt + 5'd1;
							if (tile_cnt == 5'(TILES - 1))
								state <= bg_pkg::f_idle;
							else
								state <= bg_pkg::f_map_req;
						end
						else
							state <= bg_pkg::f_row_req;
					end
				default:
					state <= bg_pkg::f_idle;
			endcase
		end
	end

endmodule

`default_nettype wire
